//--- verilog/alu_pkg.sv
// Shared types and constants of the integer execution block, referenced by scoped name

package alu_pkg;

  // Operand and result width
  localparam int data_width = 32;

  // One shift-add iteration per multiplier operand bit
  localparam int mul_steps = data_width;

  // Opcodes
  // Encoding 3 has no name and is treated as invalid
  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_mul = 2'd2
  } alu_op_e;

  // Request from the issuing stage
  // Valid in the cycle that start is high
  typedef struct packed {
    alu_op_e                op;
    logic [data_width-1:0]  a;
    logic [data_width-1:0]  b;
  } alu_req_t;

  // Response to the issuing stage
  // Valid with done and held until the next done
  typedef struct packed {
    logic [data_width-1:0]  result;
    // Set when result is all zeros
    logic                   zero;
    // Adder carry out, or nonzero upper product half
    logic                   carry;
  } alu_rsp_t;

  // Control FSM states
  typedef enum logic {
    idle     = 1'b0,
    mul_wait = 1'b1
  } ctrl_state_e;

endpackage

//--- verilog/adder.sv
// Combinational ripple-carry adder shared by add and subtract in the execution block
`timescale 1ns/1ps

module adder (
  input  logic [alu_pkg::data_width-1:0] a,
  input  logic [alu_pkg::data_width-1:0] b,
  input  logic                           cin,
  output logic [alu_pkg::data_width-1:0] sum,
  output logic                           cout
);

  // Carry chain
  // Entry i is the carry into bit i
  logic [alu_pkg::data_width:0] carry;

  assign carry[0] = cin;

  // One full-adder stage per bit, low bit first
  for (genvar i = 0; i < alu_pkg::data_width; i++)
  begin : g_stage
    logic half;

    // Propagate term of this stage
    assign half = a[i] ^ b[i];

    // Sum bit
    assign sum[i] = half ^ carry[i];

    // Generate, or propagate the incoming carry
    assign carry[i+1] = (a[i] & b[i]) | (half & carry[i]);
  end

  // Carry out of the top stage
  assign cout = carry[alu_pkg::data_width];

endmodule

//--- verilog/multiplier.sv
// Iterative unsigned shift-add multiplier with a 64-bit product, started by a one-cycle strobe
`timescale 1ns/1ps

module multiplier (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [alu_pkg::data_width-1:0]   a,
  input  logic [alu_pkg::data_width-1:0]   b,
  output logic [2*alu_pkg::data_width-1:0] product,
  output logic                             done
);

  // Step counter wide enough to hold mul_steps
  typedef logic [$clog2(alu_pkg::mul_steps + 1)-1:0] count_t;

  // Remaining iterations
  // Zero means idle
  count_t count;

  // Multiplicand, shifted left each step
  logic [2*alu_pkg::data_width-1:0] mcand;

  // Multiplier operand, shifted right each step
  logic [alu_pkg::data_width-1:0] mplier;

  // Partial product
  logic [2*alu_pkg::data_width-1:0] acc;

  // Partial product after this cycle's step
  logic [2*alu_pkg::data_width-1:0] acc_next;

  // Running while steps remain
  logic running;

  assign running = (count != '0);

  // Add the shifted multiplicand when the current operand bit is set
  always_comb
  begin
    acc_next = acc;
    if (mplier[0])
    begin
      acc_next = acc + mcand;
    end
  end

  // Step counter
  // Loaded on start, counts down once per iteration
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else if (start)
    begin
      count <= count_t'(alu_pkg::mul_steps);
    end
    else if (running)
    begin
      count <= count - count_t'(1);
    end
  end

  // Datapath registers
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      // Zero-extend the multiplicand into the wide register
      mcand  <= {{alu_pkg::data_width{1'b0}}, a};
      mplier <= b;
      acc    <= '0;
    end
    else if (running)
    begin
      acc    <= acc_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Last iteration in progress
  // The final step's sum is the full product, so it is shown combinationally
  assign done    = (count == count_t'(1));
  assign product = acc_next;

endmodule

//--- verilog/alu_ctrl.sv
// Control FSM of the execution block: decodes requests, drives the datapath, registers the response
`timescale 1ns/1ps

module alu_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  alu_pkg::alu_req_t                req,
  output logic [alu_pkg::data_width-1:0]   add_a,
  output logic [alu_pkg::data_width-1:0]   add_b,
  output logic                             add_cin,
  input  logic [alu_pkg::data_width-1:0]   sum,
  input  logic                             cout,
  output logic                             mul_start,
  output logic [alu_pkg::data_width-1:0]   mul_a,
  output logic [alu_pkg::data_width-1:0]   mul_b,
  input  logic [2*alu_pkg::data_width-1:0] product,
  input  logic                             mul_done,
  output alu_pkg::alu_rsp_t                rsp,
  output logic                             done,
  output logic                             busy
);

  alu_pkg::ctrl_state_e state;

  // Request decode
  logic is_sub;
  logic add_take;
  logic mul_finish;

  // Low and high halves of the product
  logic [alu_pkg::data_width-1:0] prod_lo;
  logic [alu_pkg::data_width-1:0] prod_hi;

  assign is_sub = (req.op == alu_pkg::alu_sub);

  // Single-cycle op accepted only while idle
  assign add_take = start && (state == alu_pkg::idle) &&
                    ((req.op == alu_pkg::alu_add) || is_sub);

  // Multiply launched straight from the request
  // Invalid opcode matches neither term and is dropped
  assign mul_start = start && (state == alu_pkg::idle) && (req.op == alu_pkg::alu_mul);

  // Multiplier finishing its last step
  assign mul_finish = (state == alu_pkg::mul_wait) && mul_done;

  // Adder operands
  // Subtract is a + ~b + 1
  assign add_a   = req.a;
  assign add_b   = is_sub ? ~req.b : req.b;
  assign add_cin = is_sub;

  // Multiplier operands, sampled by the multiplier on mul_start
  assign mul_a = req.a;
  assign mul_b = req.b;

  assign prod_lo = product[alu_pkg::data_width-1:0];
  assign prod_hi = product[2*alu_pkg::data_width-1:alu_pkg::data_width];

  // State register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= alu_pkg::idle;
    end
    else
    begin
      case (state)
        alu_pkg::idle:
        begin
          if (mul_start)
          begin
            state <= alu_pkg::mul_wait;
          end
        end
        alu_pkg::mul_wait:
        begin
          // Starts are ignored until the product is in
          if (mul_done)
          begin
            state <= alu_pkg::idle;
          end
        end
        default:
        begin
          state <= alu_pkg::idle;
        end
      endcase
    end
  end

  // Done strobe, raised together with the registered response
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= add_take || mul_finish;
    end
  end

  // Response register, held between done strobes
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rsp <= '0;
    end
    else if (add_take)
    begin
      // Raw carry out, so subtract without borrow reports one
      rsp.result <= sum;
      rsp.zero   <= (sum == '0);
      rsp.carry  <= cout;
    end
    else if (mul_finish)
    begin
      // Carry flags a product that overflows the word
      rsp.result <= prod_lo;
      rsp.zero   <= (prod_lo == '0);
      rsp.carry  <= |prod_hi;
    end
  end

  // Busy for the whole multiply wait, drops as done rises
  assign busy = (state == alu_pkg::mul_wait);

endmodule

//--- verilog/alu.sv
// Top level of the integer execution block, wiring the control FSM to the adder and multiplier
`timescale 1ns/1ps

module alu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  alu_pkg::alu_req_t req,
  output alu_pkg::alu_rsp_t rsp,
  output logic              done,
  output logic              busy
);

  // Adder connections
  logic [alu_pkg::data_width-1:0] add_a;
  logic [alu_pkg::data_width-1:0] add_b;
  logic                           add_cin;
  logic [alu_pkg::data_width-1:0] sum;
  logic                           cout;

  // Multiplier connections
  logic                             mul_start;
  logic [alu_pkg::data_width-1:0]   mul_a;
  logic [alu_pkg::data_width-1:0]   mul_b;
  logic [2*alu_pkg::data_width-1:0] product;
  logic                             mul_done;

  // Sequencing and response
  alu_ctrl ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .req       (req),
    .add_a     (add_a),
    .add_b     (add_b),
    .add_cin   (add_cin),
    .sum       (sum),
    .cout      (cout),
    .mul_start (mul_start),
    .mul_a     (mul_a),
    .mul_b     (mul_b),
    .product   (product),
    .mul_done  (mul_done),
    .rsp       (rsp),
    .done      (done),
    .busy      (busy)
  );

  // Shared add and subtract datapath
  adder adder_inst (
    .a    (add_a),
    .b    (add_b),
    .cin  (add_cin),
    .sum  (sum),
    .cout (cout)
  );

  // Multi-cycle multiply datapath
  multiplier mult_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .product (product),
    .done    (mul_done)
  );

endmodule

//--- tb/alu_assertions.sv
// Concurrent handshake and response checks for the execution block, attached to alu by bind
`timescale 1ns/1ps

module alu_assertions (
  input logic              clk,
  input logic              rst_n,
  input logic              start,
  input alu_pkg::alu_op_e  op,
  input alu_pkg::alu_rsp_t rsp,
  input logic              done,
  input logic              busy
);

  // Failed assertion count, read by the testbench when the run ends
  int failures = 0;

  // Starts the control FSM accepts
  logic take_addsub;
  logic take_mul;

  assign take_addsub = start && !busy &&
                       ((op == alu_pkg::alu_add) || (op == alu_pkg::alu_sub));
  assign take_mul    = start && !busy && (op == alu_pkg::alu_mul);

  // Single-cycle ops answer in the next cycle
  addsub_latency: assert property (@(posedge clk) disable iff (!rst_n) take_addsub |=> done)
  else
  begin
    $error("add or subtract start without done one cycle later");
    failures++;
  end

  // Multiply answers after all iterations plus the response register
  mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    take_mul |-> ##(alu_pkg::mul_steps + 1) done)
  else
  begin
    $error("multiply start without done 33 cycles later");
    failures++;
  end

  // Busy rises right after a multiply is taken
  mul_busy: assert property (@(posedge clk) disable iff (!rst_n) take_mul |=> busy)
  else
  begin
    $error("busy not raised after multiply start");
    failures++;
  end

  // Busy has dropped by the time done appears
  done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
  else
  begin
    $error("busy still high while done is high");
    failures++;
  end

  // Reset leaves the block idle
  reset_idle: assert property (@(posedge clk) !rst_n |=> (!busy && !done))
  else
  begin
    $error("busy or done high after reset");
    failures++;
  end

  // Zero flag tracks the result on every response
  zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (rsp.zero == (rsp.result == '0)))
  else
  begin
    $error("zero flag disagrees with result");
    failures++;
  end

endmodule

// Attach the checks to every alu instance
bind alu alu_assertions alu_checks (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .op    (req.op),
  .rsp   (rsp),
  .done  (done),
  .busy  (busy)
);

//--- tb/alu_tb.sv
// Testbench for the execution block: directed and random requests checked against a reference model
`timescale 1ns/1ps

module alu_tb;

  typedef logic [alu_pkg::data_width-1:0] word_t;

  logic              clk;
  logic              rst_n;
  logic              start;
  alu_pkg::alu_req_t req;
  alu_pkg::alu_rsp_t rsp;
  logic              done;
  logic              busy;

  // Request counts per group, used for loops and the timeout
  int n_reset       = 1;
  int n_addsub_dir  = 4;
  int n_addsub_rand = 50;
  int n_mul_dir     = 4;
  int n_mul_rand    = 20;
  int n_busy        = 4;
  int n_invalid     = 2;
  int n_b2b         = 8;

  // Longest wait for a done, past the multiply latency
  int done_wait = 40;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_count  = 0;
  int cycle_limit;
  bit test_bad;

  alu alu_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .req   (req),
    .rsp   (rsp),
    .done  (done),
    .busy  (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit, worst case 34 cycles per request
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // Expected response from the operation rules
  function automatic alu_pkg::alu_rsp_t model(input alu_pkg::alu_op_e op,
                                              input word_t a, input word_t b);
    alu_pkg::alu_rsp_t r;
    logic [alu_pkg::data_width:0] wide;
    logic [2*alu_pkg::data_width-1:0] prod;
    r = '0;
    case (op)
      alu_pkg::alu_add:
      begin
        wide = {1'b0, a} + {1'b0, b};
        r.result = wide[alu_pkg::data_width-1:0];
        r.carry = wide[alu_pkg::data_width];
      end
      alu_pkg::alu_sub:
      begin
        // a + ~b + 1 carries out exactly when nothing is borrowed
        r.result = a - b;
        r.carry = (a >= b);
      end
      default:
      begin
        prod = {{alu_pkg::data_width{1'b0}}, a} * {{alu_pkg::data_width{1'b0}}, b};
        r.result = prod[alu_pkg::data_width-1:0];
        r.carry = |prod[2*alu_pkg::data_width-1:alu_pkg::data_width];
      end
    endcase
    r.zero = (r.result == '0);
    return r;
  endfunction

  task automatic check_value(input string name, input string field,
                             input word_t exp, input word_t act);
    assert (act == exp)
    else
    begin
      $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", name, field, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_rsp(input string name, input alu_pkg::alu_rsp_t exp,
                           input alu_pkg::alu_rsp_t act);
    check_value(name, "result", exp.result, act.result);
    check_value(name, "zero", word_t'(exp.zero), word_t'(act.zero));
    check_value(name, "carry", word_t'(exp.carry), word_t'(act.carry));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_bad)
    begin
      tests_failed++;
      $display("%s: failed", name);
    end
    else
    begin
      $display("%s: ok", name);
    end
  endtask

  task automatic drive_req(input alu_pkg::alu_op_e op, input word_t a, input word_t b);
    start = 1'b1;
    req.op = op;
    req.a = a;
    req.b = b;
  endtask

  // One request, waits for its done and checks latency, busy and response
  task automatic run_request(input string name, input alu_pkg::alu_op_e op,
                             input word_t a, input word_t b);
    alu_pkg::alu_rsp_t exp;
    int latency;
    int want;
    bit busy_held;
    exp = model(op, a, b);
    want = (op == alu_pkg::alu_mul) ? alu_pkg::mul_steps + 1 : 1;
    busy_held = 1'b1;
    test_bad = 1'b0;
    @(negedge clk);
    drive_req(op, a, b);
    @(negedge clk);
    start = 1'b0;
    latency = 1;
    while (!done && latency < done_wait)
    begin
      if (!busy)
      begin
        busy_held = 1'b0;
      end
      @(negedge clk);
      latency++;
    end
    assert (done)
    else
    begin
      $display("No done for %s within %0d cycles of its start", name, done_wait);
      errors++;
      test_bad = 1'b1;
    end
    if (done)
    begin
      check_value(name, "latency", word_t'(want), word_t'(latency));
      check_value(name, "busy at done", '0, word_t'(busy));
      check_rsp(name, exp, rsp);
    end
    assert (busy_held)
    else
    begin
      $display("Busy dropped during the multiply wait of %s", name);
      errors++;
      test_bad = 1'b1;
    end
    finish_test(name);
  endtask

  // Multiply with extra starts in its wait, which must all be dropped
  task automatic run_busy_starts(input string name, input word_t a, input word_t b);
    alu_pkg::alu_rsp_t exp;
    alu_pkg::alu_rsp_t got;
    int dones;
    int done_at;
    exp = model(alu_pkg::alu_mul, a, b);
    got = '0;
    dones = 0;
    done_at = 0;
    test_bad = 1'b0;
    @(negedge clk);
    drive_req(alu_pkg::alu_mul, a, b);
    for (int k = 1; k <= done_wait; k++)
    begin
      @(negedge clk);
      if (done)
      begin
        dones++;
        done_at = k;
        got = rsp;
      end
      if (k == 5 || k == 32)
      begin
        drive_req(alu_pkg::alu_add, word_t'($urandom()), word_t'($urandom()));
      end
      else if (k == 17)
      begin
        drive_req(alu_pkg::alu_mul, word_t'($urandom()), word_t'($urandom()));
      end
      else
      begin
        start = 1'b0;
      end
    end
    check_value(name, "done count", word_t'(1), word_t'(dones));
    check_value(name, "latency", word_t'(alu_pkg::mul_steps + 1), word_t'(done_at));
    check_rsp(name, exp, got);
    // Response is held after done
    check_rsp(name, exp, rsp);
    finish_test(name);
  endtask

  // Encoding 3 must give no done and no busy
  task automatic run_invalid(input string name);
    int dones;
    bit busy_seen;
    dones = 0;
    busy_seen = 1'b0;
    test_bad = 1'b0;
    @(negedge clk);
    drive_req(alu_pkg::alu_op_e'(2'd3), word_t'($urandom()), word_t'($urandom()));
    for (int k = 1; k <= done_wait; k++)
    begin
      @(negedge clk);
      start = 1'b0;
      if (done)
      begin
        dones++;
      end
      if (busy)
      begin
        busy_seen = 1'b1;
      end
    end
    check_value(name, "done count", '0, word_t'(dones));
    check_value(name, "busy seen", '0, word_t'(busy_seen));
    finish_test(name);
  endtask

  // One add or subtract per cycle, each done checked a cycle later
  task automatic run_back_to_back(input int count);
    alu_pkg::alu_rsp_t exp_q[$];
    alu_pkg::alu_rsp_t exp;
    alu_pkg::alu_op_e op;
    word_t a;
    word_t b;
    string name;
    for (int i = 0; i <= count; i++)
    begin
      @(negedge clk);
      if (i > 0)
      begin
        name = $sformatf("b2b_%0d", i - 1);
        exp = exp_q.pop_front();
        test_bad = 1'b0;
        assert (done)
        else
        begin
          $display("No done for %s in the cycle after its start", name);
          errors++;
          test_bad = 1'b1;
        end
        check_rsp(name, exp, rsp);
        finish_test(name);
      end
      if (i < count)
      begin
        op = ($urandom() % 2 == 0) ? alu_pkg::alu_add : alu_pkg::alu_sub;
        a = word_t'($urandom());
        b = word_t'($urandom());
        exp_q.push_back(model(op, a, b));
        drive_req(op, a, b);
      end
      else
      begin
        start = 1'b0;
      end
    end
  endtask

  initial
  begin
    alu_pkg::alu_op_e op;
    cycle_limit = (n_reset + n_addsub_dir + n_addsub_rand + n_mul_dir + n_mul_rand +
                   n_busy + n_invalid + n_b2b) * 34 + 100;
    void'($urandom(32'h37d07bbf));
    rst_n = 1'b0;
    start = 1'b0;
    req = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs before any request
    @(negedge clk);
    test_bad = 1'b0;
    check_value("reset_state", "done", '0, word_t'(done));
    check_value("reset_state", "busy", '0, word_t'(busy));
    check_rsp("reset_state", '0, rsp);
    finish_test("reset_state");

    run_request("add_zero", alu_pkg::alu_add, 32'h0, 32'h0);
    run_request("add_carry_out", alu_pkg::alu_add, 32'hffff_ffff, 32'h1);
    run_request("sub_equal", alu_pkg::alu_sub, 32'h1234_5678, 32'h1234_5678);
    run_request("sub_borrow", alu_pkg::alu_sub, 32'h0, 32'h1);
    for (int i = 0; i < n_addsub_rand; i++)
    begin
      op = ($urandom() % 2 == 0) ? alu_pkg::alu_add : alu_pkg::alu_sub;
      run_request($sformatf("addsub_rand_%0d", i), op,
                  word_t'($urandom()), word_t'($urandom()));
    end

    run_request("mul_by_zero", alu_pkg::alu_mul, 32'h1234_5678, 32'h0);
    run_request("mul_by_one", alu_pkg::alu_mul, 32'hdead_beef, 32'h1);
    run_request("mul_ones_squared", alu_pkg::alu_mul, 32'hffff_ffff, 32'hffff_ffff);
    run_request("mul_fits", alu_pkg::alu_mul, 32'h0000_1234, 32'h0000_5678);
    for (int i = 0; i < n_mul_rand; i++)
    begin
      run_request($sformatf("mul_rand_%0d", i), alu_pkg::alu_mul,
                  word_t'($urandom()), word_t'($urandom()));
    end

    run_busy_starts("mul_with_busy_starts", 32'h0001_0003, 32'h0002_0005);
    run_invalid("invalid_opcode");
    run_request("add_after_invalid", alu_pkg::alu_add, 32'h0000_00ff, 32'h0000_0001);
    run_back_to_back(n_b2b);

    // Let pending property evaluations settle
    repeat (2) @(negedge clk);
    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, alu_inst.alu_checks.failures);
    if (errors == 0 && alu_inst.alu_checks.failures == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/alu_pkg.sv
verilog/adder.sv
verilog/multiplier.sv
verilog/alu_ctrl.sv
verilog/alu.sv
tb/alu_assertions.sv
tb/alu_tb.sv

//--- Makefile
# Verilator lint and simulation of the integer execution block

VERILATOR  ?= verilator
TOP        := alu_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
PASS_MSG   := No errors

COMMON_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   := --lint-only -Wall $(COMMON_FLAGS)
SIM_FLAGS    := --binary -Wno-fatal -Mdir $(OBJ_DIR) $(COMMON_FLAGS)
RUN_FLAGS    := +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

build:
	$(VERILATOR) $(SIM_FLAGS)

# Pass only when the run output holds the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
